//--- Makefile
SRCS := $(shell cat move_gen.f)

obj_dir/Vmove_gen_tb: move_gen.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module move_gen_tb -f move_gen.f -o Vmove_gen_tb

run: obj_dir/Vmove_gen_tb
	@out="$$(./obj_dir/Vmove_gen_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- move_gen.f
rtl/move_gen_pkg.sv
rtl/ray_scanner.sv
rtl/move_fifo.sv
rtl/move_merger.sv
rtl/move_gen.sv
tests/move_gen_properties.sv
tests/move_gen_tb.sv

//--- rtl/move_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module move_fifo #(
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic push,
	input move_gen_pkg::move_t din,
	input logic pop,
	output move_gen_pkg::move_t dout,
	output logic empty,
	output logic full
);
	import move_gen_pkg::*;

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	move_t mem [DEPTH];
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty = count == '0;
	assign full = count == CW'(DEPTH);
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// head falls through
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/move_gen.sv
`timescale 1ns/1ps
`default_nettype none

module move_gen #(
	parameter int QUEUE_DEPTH = 8,
	parameter int OUT_DEPTH = 16
) (
	input logic clk,
	input logic reset,
	input logic start,
	input move_gen_pkg::board_t bstate,
	input logic side,
	input logic rden,
	output move_gen_pkg::move_t move_out,
	output logic empty,
	output logic done
);
	import move_gen_pkg::*;

	board_t board_latch;
	logic side_latch;

	move_t ortho_move;
	move_t ortho_head;
	logic ortho_valid;
	logic ortho_full;
	logic ortho_empty;
	logic ortho_finished;
	logic ortho_pop;

	move_t diag_move;
	move_t diag_head;
	logic diag_valid;
	logic diag_full;
	logic diag_empty;
	logic diag_finished;
	logic diag_pop;

	move_t out_move;
	logic out_push;
	logic out_full;

	always_ff @(posedge clk) begin
		if (start) begin
			board_latch <= bstate;
			side_latch <= side;
		end
	end

	ray_scanner #(.DIAGONAL(1'b0)) ortho_scan (
		.clk(clk), .reset(reset), .start(start),
		.board(board_latch), .side(side_latch), .hold(ortho_full),
		.move(ortho_move), .move_valid(ortho_valid), .finished(ortho_finished)
	);

	ray_scanner #(.DIAGONAL(1'b1)) diag_scan (
		.clk(clk), .reset(reset), .start(start),
		.board(board_latch), .side(side_latch), .hold(diag_full),
		.move(diag_move), .move_valid(diag_valid), .finished(diag_finished)
	);

	move_fifo #(.DEPTH(QUEUE_DEPTH)) ortho_queue (
		.clk(clk), .reset(reset), .clear(start),
		.push(ortho_valid), .din(ortho_move), .pop(ortho_pop),
		.dout(ortho_head), .empty(ortho_empty), .full(ortho_full)
	);

	move_fifo #(.DEPTH(QUEUE_DEPTH)) diag_queue (
		.clk(clk), .reset(reset), .clear(start),
		.push(diag_valid), .din(diag_move), .pop(diag_pop),
		.dout(diag_head), .empty(diag_empty), .full(diag_full)
	);

	move_merger merger (
		.clk(clk), .reset(reset), .start(start),
		.ortho_move(ortho_head), .ortho_empty(ortho_empty),
		.ortho_finished(ortho_finished), .ortho_pop(ortho_pop),
		.diag_move(diag_head), .diag_empty(diag_empty),
		.diag_finished(diag_finished), .diag_pop(diag_pop),
		.out_full(out_full), .out_push(out_push), .out_move(out_move),
		.done(done)
	);

	// rden while empty is dropped inside the queue
	move_fifo #(.DEPTH(OUT_DEPTH)) out_queue (
		.clk(clk), .reset(reset), .clear(start),
		.push(out_push), .din(out_move), .pop(rden),
		.dout(move_out), .empty(empty), .full(out_full)
	);

endmodule

`default_nettype wire

//--- rtl/move_gen_pkg.sv
`default_nettype none

package move_gen_pkg;

	// 64 nibbles, square i at bits 4i+3 .. 4i
	typedef logic [255:0] board_t;

	// color bit is 1 for black
	typedef struct packed {
		logic color;
		logic [2:0] kind;
	} piece_t;

	// a1 is 0, b1 is 1, a2 is 8
	typedef struct packed {
		logic [2:0] row;
		logic [2:0] col;
	} square_t;

	// flags from the top down:
	// invalid, promote, pawn move, pawn two-square, en passant, castle, capture
	typedef struct packed {
		logic [6:0] flags;
		square_t from;
		square_t to;
	} move_t;

	localparam logic [2:0] KIND_EMPTY = 3'd0;
	localparam logic [2:0] KIND_PAWN = 3'd1;
	localparam logic [2:0] KIND_KNIGHT = 3'd2;
	localparam logic [2:0] KIND_BISHOP = 3'd3;
	localparam logic [2:0] KIND_ROOK = 3'd4;
	localparam logic [2:0] KIND_QUEEN = 3'd5;
	localparam logic [2:0] KIND_KING = 3'd6;

	// only flag this design ever sets
	localparam int FLAG_CAPTURE = 0;

endpackage

`default_nettype wire

//--- rtl/move_merger.sv
`timescale 1ns/1ps
`default_nettype none

module move_merger (
	input logic clk,
	input logic reset,
	input logic start,
	input move_gen_pkg::move_t ortho_move,
	input logic ortho_empty,
	input logic ortho_finished,
	output logic ortho_pop,
	input move_gen_pkg::move_t diag_move,
	input logic diag_empty,
	input logic diag_finished,
	output logic diag_pop,
	input logic out_full,
	output logic out_push,
	output move_gen_pkg::move_t out_move,
	output logic done
);
	import move_gen_pkg::*;

	logic take_ortho;
	logic take_diag;
	logic all_clear;

	// rook-line queue has priority
	assign take_ortho = !out_full && !ortho_empty;
	assign take_diag = !out_full && ortho_empty && !diag_empty;

	assign ortho_pop = take_ortho;
	assign diag_pop = take_diag;
	assign out_push = take_ortho || take_diag;

	always_comb begin
		if (!ortho_empty)
			out_move = ortho_move;
		else
			out_move = diag_move;
	end

	// output queue may still hold moves when this is high
	assign all_clear = ortho_finished && diag_finished && ortho_empty && diag_empty;

	always_ff @(posedge clk) begin
		if (reset || start)
			done <= 1'b0;
		else if (all_clear)
			done <= 1'b1;
	end

endmodule

`default_nettype wire

//--- rtl/ray_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module ray_scanner #(
	parameter bit DIAGONAL = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic start,
	input move_gen_pkg::board_t board,
	input logic side,
	input logic hold,
	output move_gen_pkg::move_t move,
	output logic move_valid,
	output logic finished
);
	import move_gen_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_SRC,
		S_RAY,
		S_DONE
	} state_t;

	state_t state;
	square_t src;
	square_t pos;
	logic [1:0] dir;

	piece_t src_piece;
	piece_t tgt_piece;
	square_t tgt;
	logic row_inc;
	logic row_dec;
	logic col_inc;
	logic col_dec;
	logic off_edge;
	logic slider;
	logic hit_empty;
	logic hit_enemy;
	logic ray_end;

	// step direction for the current ray
	always_comb begin
		row_inc = 1'b0;
		row_dec = 1'b0;
		col_inc = 1'b0;
		col_dec = 1'b0;
		if (DIAGONAL) begin
			row_inc = ~dir[1];
			row_dec = dir[1];
			col_inc = ~dir[0];
			col_dec = dir[0];
		end else begin
			case (dir)
				2'd0: row_inc = 1'b1;
				2'd1: row_dec = 1'b1;
				2'd2: col_inc = 1'b1;
				default: col_dec = 1'b1;
			endcase
		end
	end

	assign off_edge = (row_inc && pos.row == 3'd7) || (row_dec && pos.row == 3'd0) ||
		(col_inc && pos.col == 3'd7) || (col_dec && pos.col == 3'd0);

	// wraps past the edge, only used when off_edge is low
	always_comb begin
		tgt.row = pos.row + {2'b00, row_inc} - {2'b00, row_dec};
		tgt.col = pos.col + {2'b00, col_inc} - {2'b00, col_dec};
	end

	assign src_piece = board[{src, 2'b00} +: 4];
	assign tgt_piece = board[{tgt, 2'b00} +: 4];

	assign slider = (src_piece.color == side) && ((src_piece.kind == KIND_QUEEN) ||
		(src_piece.kind == (DIAGONAL ? KIND_BISHOP : KIND_ROOK)));

	assign hit_empty = tgt_piece.kind == KIND_EMPTY;
	assign hit_enemy = !hit_empty && (tgt_piece.color != side);
	assign ray_end = off_edge || !hit_empty;

	assign move_valid = (state == S_RAY) && !hold && !off_edge && (hit_empty || hit_enemy);

	always_comb begin
		move.flags = '0;
		move.flags[FLAG_CAPTURE] = hit_enemy;
		move.from = src;
		move.to = tgt;
	end

	assign finished = state == S_DONE;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			src <= '0;
			pos <= '0;
			dir <= '0;
		end else if (start) begin
			state <= S_SRC;
			src <= '0;
			pos <= '0;
			dir <= '0;
		end else if (!hold) begin
			case (state)
				S_SRC: begin
					if (slider) begin
						state <= S_RAY;
						pos <= src;
						dir <= 2'd0;
					end else if (src == 6'd63) begin
						state <= S_DONE;
					end else begin
						src <= src + 6'd1;
					end
				end
				S_RAY: begin
					if (!ray_end) begin
						pos <= tgt;
					end else if (dir != 2'd3) begin
						// next direction restarts at the source
						dir <= dir + 2'd1;
						pos <= src;
					end else if (src == 6'd63) begin
						state <= S_DONE;
					end else begin
						state <= S_SRC;
						src <= src + 6'd1;
					end
				end
				default: begin
					state <= state;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- tests/move_gen_properties.sv
`timescale 1ns/1ps
`default_nettype none

module move_gen_properties (
	input logic clk,
	input logic reset,
	input logic start,
	input logic rden,
	input logic empty,
	input logic done,
	input move_gen_pkg::move_t move_out
);
	import move_gen_pkg::*;

	done_falls_after_start: assert property (
		@(posedge clk) disable iff (reset)
		start |=> !done
	) else $error("done still high the cycle after start");

	// head must not change until it is read
	head_held: assert property (
		@(posedge clk) disable iff (reset)
		(!empty && !rden && !start) |=> $stable(move_out)
	) else $error("move_out changed while waiting to be read");

	no_invalid_flag: assert property (
		@(posedge clk) disable iff (reset)
		!empty |-> !move_out.flags[6]
	) else $error("invalid flag set on a visible move");

	done_low_after_reset: assert property (
		@(posedge clk)
		reset |=> !done
	) else $error("done high after reset");

endmodule

bind move_gen move_gen_properties props (
	.clk(clk), .reset(reset), .start(start), .rden(rden),
	.empty(empty), .done(done), .move_out(move_out)
);

`default_nettype wire

//--- tests/move_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module move_gen_tb;
	import move_gen_pkg::*;

	localparam int RANDOM_BOARDS = 16;
	localparam int CROWDED_BOARDS = 4;
	localparam int NUM_BOARDS = 5 + RANDOM_BOARDS + CROWDED_BOARDS;

	logic clk = 1'b0;
	logic reset;
	logic start;
	board_t bstate;
	logic side;
	logic rden;
	move_t move_out;
	logic empty;
	logic done;

	// expected moves, indexed by from and to square
	logic exp_valid [64][64];
	logic [6:0] exp_flags [64][64];
	logic seen [64][64];
	int exp_count;
	int want_count;
	int want_captures;

	logic stall_mode;
	int gap;
	int burst;

	move_t got_move;
	int read_count = 0;
	int capture_count = 0;
	int boards_done = 0;
	int errors = 0;
	logic pending = 1'b0;

	move_gen UUT (
		.clk(clk), .reset(reset), .start(start), .bstate(bstate), .side(side),
		.rden(rden), .move_out(move_out), .empty(empty), .done(done)
	);

	always #4 clk = ~clk;

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Error: %s = %h, expected %h", name, got, expected);
			errors++;
		end
	endtask

	function automatic board_t put_piece(input board_t b, input int sq, input logic color,
		input logic [2:0] kind);
		board_t r;
		r = b;
		r[4*sq +: 4] = {color, kind};
		return r;
	endfunction

	function automatic board_t random_board(input int fill_pct, input logic sliders_only);
		board_t b;
		logic [2:0] k;
		b = '0;
		for (int i = 0; i < 64; i++) begin
			if ($urandom % 100 < fill_pct) begin
				if (sliders_only)
					k = 3'(3 + $urandom % 3);
				else
					k = 3'(1 + $urandom % 6);
				b[4*i +: 4] = {1'($urandom % 2), k};
			end
		end
		return b;
	endfunction

	// walks every ray of every slider of side s and fills the expected table
	function automatic int expect_moves(input board_t b, input logic s);
		int n;
		int r;
		int c;
		int t;
		int dr;
		int dc;
		logic [3:0] p;
		logic [3:0] tp;
		logic slides;
		logic stop;
		n = 0;
		for (int f = 0; f < 64; f++) begin
			for (int g = 0; g < 64; g++) begin
				exp_valid[f][g] = 1'b0;
				exp_flags[f][g] = '0;
			end
		end
		for (int sq = 0; sq < 64; sq++) begin
			p = b[4*sq +: 4];
			for (int d = 0; d < 8; d++) begin
				// 0..3 rook lines, 4..7 diagonals
				if (d < 4) begin
					slides = p[2:0] == KIND_ROOK || p[2:0] == KIND_QUEEN;
					dr = (d == 0) ? 1 : (d == 1) ? -1 : 0;
					dc = (d == 2) ? 1 : (d == 3) ? -1 : 0;
				end else begin
					slides = p[2:0] == KIND_BISHOP || p[2:0] == KIND_QUEEN;
					dr = (d < 6) ? 1 : -1;
					dc = (d % 2 == 0) ? 1 : -1;
				end
				stop = !slides || p[3] != s;
				r = sq / 8 + dr;
				c = sq % 8 + dc;
				while (!stop && r >= 0 && r < 8 && c >= 0 && c < 8) begin
					t = r * 8 + c;
					tp = b[4*t +: 4];
					if (tp[2:0] == KIND_EMPTY) begin
						exp_valid[sq][t] = 1'b1;
						n++;
					end else begin
						if (tp[3] != s) begin
							exp_valid[sq][t] = 1'b1;
							exp_flags[sq][t][FLAG_CAPTURE] = 1'b1;
							n++;
						end
						stop = 1'b1;
					end
					r += dr;
					c += dc;
				end
			end
		end
		return n;
	endfunction

	task automatic run_board(input board_t b, input logic s, input int want,
		input int want_cap);
		int target;
		exp_count = expect_moves(b, s);
		want_count = want;
		want_captures = want_cap;
		target = boards_done + 1;
		@(posedge clk);
		#1;
		bstate = b;
		side = s;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		while (boards_done != target)
			@(posedge clk);
	endtask

	// comparing process, samples between the edges
	always @(negedge clk) begin
		if (start) begin
			for (int f = 0; f < 64; f++) begin
				for (int g = 0; g < 64; g++)
					seen[f][g] = 1'b0;
			end
			read_count = 0;
			capture_count = 0;
			pending = 1'b1;
		end else if (rden && !empty) begin
			got_move = move_out;
			if (!exp_valid[got_move.from][got_move.to]) begin
				$display("unexpected move from square %0d to square %0d was read",
					got_move.from, got_move.to);
				errors++;
			end else if (seen[got_move.from][got_move.to]) begin
				$display("move from square %0d to square %0d was read twice",
					got_move.from, got_move.to);
				errors++;
			end else begin
				compare_value("move_out.flags", 32'(got_move.flags),
					32'(exp_flags[got_move.from][got_move.to]));
				seen[got_move.from][got_move.to] = 1'b1;
			end
			read_count++;
			if (got_move.flags[FLAG_CAPTURE])
				capture_count++;
		end else if (pending && done && empty) begin
			for (int f = 0; f < 64; f++) begin
				for (int g = 0; g < 64; g++) begin
					if (exp_valid[f][g] && !seen[f][g]) begin
						$display("move from square %0d to square %0d was never read", f, g);
						errors++;
					end
				end
			end
			compare_value("move count", read_count, exp_count);
			if (want_count >= 0)
				compare_value("directed move count", read_count, want_count);
			if (want_captures >= 0)
				compare_value("capture count", capture_count, want_captures);
			pending = 1'b0;
			boards_done++;
		end
	end

	// reads every cycle, or long stalls with short bursts
	initial begin
		rden = 1'b0;
		gap = 0;
		burst = 0;
		forever begin
			@(posedge clk);
			#1;
			if (!stall_mode) begin
				rden = 1'b1;
			end else if (gap > 0) begin
				rden = 1'b0;
				gap--;
			end else begin
				rden = 1'b1;
				if (burst > 1) begin
					burst--;
				end else begin
					gap = 8 + $urandom % 24;
					burst = 1 + $urandom % 3;
				end
			end
		end
	end

	initial begin
		repeat (NUM_BOARDS * 64 * 30) @(posedge clk);
		$display("watchdog expired after %0d of %0d boards", boards_done, NUM_BOARDS);
		$display("Test failed");
		$finish;
	end

	initial begin
		board_t b;
		void'($urandom(32'h80de));
		reset = 1'b1;
		start = 1'b0;
		bstate = '0;
		side = 1'b0;
		stall_mode = 1'b0;
		want_count = -1;
		want_captures = -1;
		exp_count = 0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// only black pieces, white to move
		b = put_piece('0, 0, 1'b1, KIND_ROOK);
		b = put_piece(b, 63, 1'b1, KIND_QUEEN);
		run_board(b, 1'b0, 0, 0);

		// lone rook on d4
		run_board(put_piece('0, 27, 1'b0, KIND_ROOK), 1'b0, 14, 0);

		// queen on d4, own pawn d6 and knight e3, black rook b4 and knight f6
		b = put_piece('0, 27, 1'b0, KIND_QUEEN);
		b = put_piece(b, 43, 1'b0, KIND_PAWN);
		b = put_piece(b, 20, 1'b0, KIND_KNIGHT);
		b = put_piece(b, 25, 1'b1, KIND_ROOK);
		b = put_piece(b, 45, 1'b1, KIND_KNIGHT);
		run_board(b, 1'b0, 18, 2);

		// white has no sliders, black rook h8 and bishop c8 both hit h3
		b = put_piece('0, 12, 1'b0, KIND_PAWN);
		b = put_piece(b, 23, 1'b0, KIND_KNIGHT);
		b = put_piece(b, 4, 1'b0, KIND_KING);
		b = put_piece(b, 63, 1'b1, KIND_ROOK);
		b = put_piece(b, 58, 1'b1, KIND_BISHOP);
		run_board(b, 1'b0, 0, 0);
		run_board(b, 1'b1, 16, 2);

		for (int i = 0; i < RANDOM_BOARDS; i++)
			run_board(random_board(30, 1'b0), 1'($urandom % 2), -1, -1);

		stall_mode = 1'b1;
		for (int i = 0; i < CROWDED_BOARDS; i++)
			run_board(random_board(35, 1'b1), 1'($urandom % 2), -1, -1);
		stall_mode = 1'b0;

		@(posedge clk);
		#1;
		$display("%0d boards checked, %0d errors", boards_done, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
